//--- hw/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // region code lives in address bits 31:16
  localparam logic [15:0] REGION_SRAM = 16'h0200;
  localparam logic [15:0] REGION_IRQ  = 16'h0202;
  localparam logic [15:0] REGION_KEYB = 16'h0207;

  typedef enum logic [1:0] {
    REG_SRAM,
    REG_IRQ,
    REG_KEYB,
    REG_NONE
  } region_e;

  localparam int IRQ_W     = 3;
  localparam int IRQ_TIMER = 0;
  localparam int IRQ_UART  = 1;
  localparam int IRQ_KEYB  = 2;

  localparam int KB_FRAME_BITS = 11; // start, 8 data, parity, stop

  typedef enum logic {
    KB_IDLE,
    KB_SHIFT
  } kb_state_e;

endpackage

//--- hw/bus_fabric.sv
module bus_fabric import soc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [ADDR_W-1:0] bus_address,
  input  logic              bus_read,
  input  logic              bus_write,
  output logic [DATA_W-1:0] bus_readdata,
  output logic              bus_waitrequest,
  output logic [13:0]       offset,
  output logic              sram_read,
  output logic              sram_write,
  input  logic [DATA_W-1:0] sram_readdata,
  input  logic              sram_waitrequest,
  output logic              irq_write,
  input  logic [DATA_W-1:0] irq_readdata,
  output logic              kb_read,
  input  logic [DATA_W-1:0] kb_readdata
);

  region_e region;

  always_comb begin
    case (bus_address[31:16])
      REGION_SRAM: region = REG_SRAM;
      REGION_IRQ:  region = REG_IRQ;
      REGION_KEYB: region = REG_KEYB;
      default:     region = REG_NONE; // unmapped, reads 0
    endcase
  end

  assign offset = bus_address[15:2]; // word offset inside region

  // private strobes, high only for the addressed slave
  assign sram_read  = (region == REG_SRAM) && bus_read;
  assign sram_write = (region == REG_SRAM) && bus_write;
  assign irq_write  = (region == REG_IRQ) && bus_write;
  assign kb_read    = (region == REG_KEYB) && bus_read;

  always_comb begin
    bus_waitrequest = 1'b0; // only the SRAM stalls
    case (region)
      REG_SRAM: begin
        bus_readdata    = sram_readdata;
        bus_waitrequest = sram_waitrequest;
      end
      REG_IRQ:  bus_readdata = irq_readdata;
      REG_KEYB: bus_readdata = kb_readdata;
      default:  bus_readdata = '0;
    endcase
  end

  // master must never issue read and write in the same cycle
  a_no_rd_wr: assert property (
    @(posedge clk) disable iff (!reset_n) !(bus_read && bus_write)
  );

endmodule

//--- hw/main_sram.sv
module main_sram import soc_pkg::*; #(
  parameter int SRAM_WORDS = 512
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [13:0]       offset,
  input  logic              sram_read,
  input  logic              sram_write,
  input  logic [DATA_W-1:0] writedata,
  input  logic [BE_W-1:0]   byteenable,
  output logic [DATA_W-1:0] sram_readdata,
  output logic              sram_waitrequest
);

  localparam int AW = $clog2(SRAM_WORDS);

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [DATA_W-1:0] rdata;
  logic [AW-1:0]     addr;
  logic              read_ack;

  assign addr = AW'(offset % SRAM_WORDS); // wraps past the top word

  always_ff @(posedge clk) begin
    if (sram_write) begin
      for (int b = 0; b < BE_W; b++) begin
        if (byteenable[b]) begin
          mem[addr][b*8 +: 8] <= writedata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rdata <= mem[addr]; // valid one cycle after the address
  end

  // ack is high in the second cycle of a read, then drops.
  // Back-to-back reads each get their own wait cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else begin
      read_ack <= sram_read && !read_ack;
    end
  end

  assign sram_waitrequest = sram_read && !read_ack;
  assign sram_readdata    = rdata;

  a_one_wait: assert property (
    @(posedge clk) disable iff (!reset_n) sram_waitrequest |=> !sram_waitrequest
  );

endmodule

//--- hw/irq_ctrl.sv
module irq_ctrl import soc_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [13:0]       offset,
  input  logic              irq_write,
  input  logic [DATA_W-1:0] writedata,
  output logic [DATA_W-1:0] irq_readdata,
  input  logic [1:0]        ext_irq,
  input  logic              kb_frame_done,
  output logic              irq
);

  logic [1:0]       ext_s0;
  logic [1:0]       ext_s1;
  logic [1:0]       ext_prev;
  logic [1:0]       ext_rise;
  logic [IRQ_W-1:0] set_bits;
  logic [IRQ_W-1:0] pending;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ext_s0   <= '0;
      ext_s1   <= '0;
      ext_prev <= '0;
    end else begin
      ext_s0   <= ext_irq; // 2-flop sync
      ext_s1   <= ext_s0;
      ext_prev <= ext_s1;
    end
  end

  assign ext_rise = ext_s1 & ~ext_prev;

  always_comb begin
    set_bits            = '0;
    set_bits[IRQ_TIMER] = ext_rise[0];
    set_bits[IRQ_UART]  = ext_rise[1];
    set_bits[IRQ_KEYB]  = kb_frame_done;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending <= '0;
    end else if (irq_write && offset == '0) begin
      pending <= (pending & ~writedata[IRQ_W-1:0]) | set_bits; // set beats clear
    end else begin
      pending <= pending | set_bits;
    end
  end

  assign irq_readdata = {{(DATA_W-IRQ_W){1'b0}}, pending}; // any offset
  assign irq          = |pending;

  // a new source raises irq next cycle, even against a clear
  a_irq_level: assert property (
    @(posedge clk) disable iff (!reset_n) (|set_bits) |=> irq
  );

endmodule

//--- hw/ps2_keyboard.sv
module ps2_keyboard import soc_pkg::*; #(
  parameter int KB_TIMEOUT = 65535
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              kb_read,
  output logic [DATA_W-1:0] kb_readdata,
  output logic              kb_frame_done,
  input  logic              ps2_clk,
  input  logic              ps2_data
);

  localparam int IDLE_W = $clog2(KB_TIMEOUT + 1);
  localparam int CNT_W  = $clog2(KB_FRAME_BITS);

  logic                     clk_s0;
  logic                     clk_s1;
  logic                     clk_prev;
  logic                     data_s0;
  logic                     data_s1;
  logic                     clk_rise;
  logic                     start;
  kb_state_e                state;
  logic [CNT_W-1:0]         bit_cnt;
  logic [IDLE_W-1:0]        idle_cnt;
  logic [KB_FRAME_BITS-1:0] shift;
  logic [KB_FRAME_BITS-1:0] kb_data;
  logic                     valid;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_s0   <= 1'b1; // lines idle high
      clk_s1   <= 1'b1;
      clk_prev <= 1'b1;
      data_s0  <= 1'b1;
      data_s1  <= 1'b1;
    end else begin
      clk_s0   <= ps2_clk;
      clk_s1   <= clk_s0;
      clk_prev <= clk_s1;
      data_s0  <= ps2_data;
      data_s1  <= data_s0;
    end
  end

  assign clk_rise = clk_s1 && !clk_prev;
  // a stalled partial frame is dropped on the next edge
  assign start    = (state == KB_IDLE) || (idle_cnt == IDLE_W'(KB_TIMEOUT));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= KB_IDLE;
      bit_cnt       <= '0;
      idle_cnt      <= '0;
      valid         <= 1'b0;
      kb_frame_done <= 1'b0;
    end else begin
      kb_frame_done <= 1'b0;
      if (kb_read) begin
        valid <= 1'b0; // read clears
      end
      if (idle_cnt != IDLE_W'(KB_TIMEOUT)) begin
        idle_cnt <= idle_cnt + 1'b1;
      end
      if (clk_rise) begin
        idle_cnt <= '0;
        if (start) begin
          state   <= KB_SHIFT;
          bit_cnt <= CNT_W'(1);
        end else if (bit_cnt == CNT_W'(KB_FRAME_BITS - 1)) begin
          state         <= KB_IDLE;
          bit_cnt       <= '0;
          valid         <= 1'b1; // new frame overwrites unread one
          kb_frame_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_rise) begin
      if (start) begin
        shift[0] <= data_s1;
      end else begin
        shift[bit_cnt] <= data_s1;
      end
      if (!start && bit_cnt == CNT_W'(KB_FRAME_BITS - 1)) begin
        kb_data <= {data_s1, shift[KB_FRAME_BITS-2:0]}; // stop bit on top
      end
    end
  end

  assign kb_readdata = {{(DATA_W-KB_FRAME_BITS-1){1'b0}}, valid, kb_data};

  a_bit_range: assert property (
    @(posedge clk) disable iff (!reset_n) bit_cnt < CNT_W'(KB_FRAME_BITS)
  );

endmodule

//--- hw/periph_top.sv
module periph_top import soc_pkg::*; #(
  parameter int SRAM_WORDS = 512,
  parameter int KB_TIMEOUT = 65535
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [ADDR_W-1:0] bus_address,
  input  logic              bus_read,
  input  logic              bus_write,
  input  logic [DATA_W-1:0] bus_writedata,
  input  logic [BE_W-1:0]   bus_byteenable,
  output logic [DATA_W-1:0] bus_readdata,
  output logic              bus_waitrequest,
  input  logic [1:0]        ext_irq,
  output logic              irq,
  input  logic              ps2_clk,
  input  logic              ps2_data
);

  logic [13:0]       offset;
  logic              sram_read;
  logic              sram_write;
  logic [DATA_W-1:0] sram_readdata;
  logic              sram_waitrequest;
  logic              irq_write;
  logic [DATA_W-1:0] irq_readdata;
  logic              kb_read;
  logic [DATA_W-1:0] kb_readdata;
  logic              kb_frame_done; // keyboard interrupt source

  bus_fabric bus_fabric_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .bus_address      (bus_address),
    .bus_read         (bus_read),
    .bus_write        (bus_write),
    .bus_readdata     (bus_readdata),
    .bus_waitrequest  (bus_waitrequest),
    .offset           (offset),
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .sram_readdata    (sram_readdata),
    .sram_waitrequest (sram_waitrequest),
    .irq_write        (irq_write),
    .irq_readdata     (irq_readdata),
    .kb_read          (kb_read),
    .kb_readdata      (kb_readdata)
  );

  main_sram #(
    .SRAM_WORDS (SRAM_WORDS)
  ) main_sram_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .offset           (offset),
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .writedata        (bus_writedata),
    .byteenable       (bus_byteenable),
    .sram_readdata    (sram_readdata),
    .sram_waitrequest (sram_waitrequest)
  );

  irq_ctrl irq_ctrl_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .offset        (offset),
    .irq_write     (irq_write),
    .writedata     (bus_writedata),
    .irq_readdata  (irq_readdata),
    .ext_irq       (ext_irq),
    .kb_frame_done (kb_frame_done),
    .irq           (irq)
  );

  ps2_keyboard #(
    .KB_TIMEOUT (KB_TIMEOUT)
  ) ps2_keyboard_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .kb_read       (kb_read),
    .kb_readdata   (kb_readdata),
    .kb_frame_done (kb_frame_done),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data)
  );

endmodule

//--- include/tb_bus.svh
`ifndef TB_BUS_SVH
`define TB_BUS_SVH

// all bus tasks start and end 2 time units after a rising edge
// wait_count ends up with the stalled cycles of the transfer
task automatic bus_write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BE_W-1:0] be);
  bus_address    = addr;
  bus_writedata  = data;
  bus_byteenable = be;
  bus_write      = 1'b1;
  wait_count     = 0;
  @(negedge clk); // mid-cycle sample
  while (bus_waitrequest) begin
    wait_count++;
    @(negedge clk);
  end
  @(posedge clk);
  #2;
  bus_write = 1'b0;
endtask

task automatic bus_read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
  bus_address = addr;
  bus_read    = 1'b1;
  wait_count  = 0;
  @(negedge clk);
  while (bus_waitrequest) begin
    wait_count++;
    @(negedge clk);
  end
  data = bus_readdata; // valid in the completing cycle
  @(posedge clk);
  #2;
  bus_read = 1'b0;
endtask

// device side of PS/2, data set while the clock is low
task automatic ps2_send_bits(input logic [KB_FRAME_BITS-1:0] frame, input int nbits);
  for (int i = 0; i < nbits; i++) begin
    ps2_clk  = 1'b0;
    ps2_data = frame[i];
    wait_cycles(PS2_HALF);
    ps2_clk = 1'b1; // receiver samples here
    wait_cycles(PS2_HALF);
  end
  ps2_data = 1'b1;
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [BE_W-1:0]   be);
  logic [DATA_W-1:0] merged;
  merged = old_word;
  for (int b = 0; b < BE_W; b++) begin
    if (be[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
  end
  return merged;
endfunction

// valid at bit 11, then stop, odd parity, data lsb first, start
function automatic logic [DATA_W-1:0] kb_expect(input logic [7:0] b);
  return {20'd0, 1'b1, 1'b1, ~^b, b, 1'b0};
endfunction

`endif

//--- tb/tb_top.sv
module tb_top import soc_pkg::*;;

  localparam int SRAM_WORDS     = 512;
  localparam int KB_TIMEOUT     = 200;
  localparam int PS2_HALF       = 10; // clock cycles per PS/2 half period
  localparam int FRAME_CYCLES   = KB_FRAME_BITS * 2 * PS2_HALF;
  // about 12 frames plus SRAM fill and bus traffic, with margin
  localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES + 17360;

  logic              clk;
  logic              reset_n;
  logic [ADDR_W-1:0] bus_address;
  logic              bus_read;
  logic              bus_write;
  logic [DATA_W-1:0] bus_writedata;
  logic [BE_W-1:0]   bus_byteenable;
  logic [DATA_W-1:0] bus_readdata;
  logic              bus_waitrequest;
  logic [1:0]        ext_irq;
  logic              irq;
  logic              ps2_clk;
  logic              ps2_data;

  logic [DATA_W-1:0] model [SRAM_WORDS]; // reference copy of the SRAM
  logic [31:0]       rng_state;
  string             name_q[$];
  logic [DATA_W-1:0] exp_q[$];
  logic [DATA_W-1:0] act_q[$];
  string             cmp_name;
  logic [DATA_W-1:0] cmp_exp;
  logic [DATA_W-1:0] cmp_act;
  int                check_count;
  int                error_count;
  int                tests_run;
  int                tests_failed;
  int                errors_at_start;
  int                checks_at_start;
  int                cycle_count;
  int                wait_count; // stalled cycles of the last bus transfer

  periph_top #(
    .SRAM_WORDS (SRAM_WORDS),
    .KB_TIMEOUT (KB_TIMEOUT)
  ) periph_top_inst (
    .clk             (clk),
    .reset_n         (reset_n),
    .bus_address     (bus_address),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .ext_irq         (ext_irq),
    .irq             (irq),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data)
  );

  always #10 clk = ~clk;

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  `include "tb_bus.svh"

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input logic [15:0] region, input int word);
    return {region, word[13:0], 2'b00};
  endfunction

  function automatic logic [DATA_W-1:0] fill_pattern(input int word);
    return {~word[15:0], word[15:0]} ^ 32'h5a3c_96e1;
  endfunction

  task automatic expect_value(input string name, input logic [DATA_W-1:0] exp_val,
                              input logic [DATA_W-1:0] act_val);
    name_q.push_back(name);
    exp_q.push_back(exp_val);
    act_q.push_back(act_val);
  endtask

  // stall cycles of the transfer that just finished
  task automatic expect_waits(input string name, input int exp_waits);
    expect_value(name, DATA_W'(exp_waits), DATA_W'(wait_count));
  endtask

  // compare process, pops pending checks as the tests queue them
  always begin
    wait (act_q.size() != 0);
    cmp_name = name_q.pop_front();
    cmp_exp  = exp_q.pop_front();
    cmp_act  = act_q.pop_front();
    check_count++;
    assert (cmp_act === cmp_exp) else begin
      $display("CHECK FAILED test=%s expected=%h actual=%h", cmp_name, cmp_exp, cmp_act);
      error_count++;
    end
  end

  task automatic report_failure(input string msg);
    $display("ERROR %s", msg);
    error_count++;
  endtask

  task automatic start_test();
    errors_at_start = error_count;
    checks_at_start = check_count;
  endtask

  task automatic finish_test(input string name);
    wait (act_q.size() == 0);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %-12s ok (%0d checks)", name, check_count - checks_at_start);
    end else begin
      tests_failed++;
      $display("test %-12s failed (%0d errors)", name, error_count - errors_at_start);
    end
  endtask

  task automatic poll_keyboard(output logic [DATA_W-1:0] value);
    for (int i = 0; i < 10; i++) begin
      bus_read_word(word_addr(REGION_KEYB, 0), value);
      if (value[11]) break;
    end
    if (!value[11]) report_failure("keyboard valid bit never set after a frame");
  endtask

  task automatic run_sram_random();
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic [31:0]       r;
    int                word;
    start_test();
    for (int i = 0; i < SRAM_WORDS; i++) begin
      bus_write_word(word_addr(REGION_SRAM, i), fill_pattern(i), 4'hf);
      model[i] = fill_pattern(i);
    end
    for (int n = 0; n < 64; n++) begin
      r     = next_rand();
      word  = int'(r % SRAM_WORDS);
      wdata = next_rand();
      r     = next_rand(); // low nibble is the byte enable
      bus_write_word(word_addr(REGION_SRAM, word), wdata, r[3:0]);
      expect_waits("sram_wait", 0);
      model[word] = merge_bytes(model[word], wdata, r[3:0]);
      bus_read_word(word_addr(REGION_SRAM, word), rdata);
      expect_waits("sram_wait", 1);
      expect_value("sram_random", model[word], rdata);
      r    = next_rand();
      word = int'(r % SRAM_WORDS);
      bus_read_word(word_addr(REGION_SRAM, word), rdata);
      expect_waits("sram_wait", 1);
      expect_value("sram_random", model[word], rdata);
    end
    finish_test("sram_random");
  endtask

  task automatic run_unmapped();
    logic [DATA_W-1:0] rdata;
    start_test();
    bus_read_word(word_addr(16'h0300, 5), rdata);
    expect_waits("unmapped_wait", 0);
    expect_value("unmapped", '0, rdata);
    bus_write_word(word_addr(16'h0300, 5), 32'hdead_beef, 4'hf); // same offset as SRAM word 5
    bus_read_word(word_addr(REGION_SRAM, 5), rdata);
    expect_value("unmapped", model[5], rdata);
    finish_test("unmapped");
  endtask

  task automatic run_kb_frame();
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] frame;
    logic [31:0]       r;
    start_test();
    r     = next_rand();
    frame = kb_expect(r[7:0]);
    ps2_send_bits(frame[KB_FRAME_BITS-1:0], KB_FRAME_BITS);
    poll_keyboard(rdata);
    expect_value("kb_frame", frame, rdata);
    bus_read_word(word_addr(REGION_KEYB, 0), rdata);
    expect_value("kb_frame", 32'd0, {31'd0, rdata[11]}); // read cleared valid
    finish_test("kb_frame");
  endtask

  task automatic run_kb_resync();
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] frame;
    logic [31:0]       r;
    start_test();
    r     = next_rand();
    frame = kb_expect(r[7:0]);
    ps2_send_bits(frame[KB_FRAME_BITS-1:0], 4); // partial frame
    wait_cycles(300);
    r     = next_rand();
    frame = kb_expect(r[7:0]);
    ps2_send_bits(frame[KB_FRAME_BITS-1:0], KB_FRAME_BITS);
    poll_keyboard(rdata);
    expect_value("kb_resync", frame, rdata);
    finish_test("kb_resync");
  endtask

  task automatic run_irq();
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] frame;
    logic [31:0]       r;
    start_test();
    bus_write_word(word_addr(REGION_IRQ, 0), 32'd7, 4'hf); // drop keyboard bits from earlier
    bus_read_word(word_addr(REGION_IRQ, 0), rdata);
    expect_value("irq", 32'd0, rdata);
    ext_irq[0] = 1'b1;
    wait_cycles(4);
    ext_irq[0] = 1'b0;
    r     = next_rand();
    frame = kb_expect(r[7:0]);
    ps2_send_bits(frame[KB_FRAME_BITS-1:0], KB_FRAME_BITS);
    for (int i = 0; i < 10; i++) begin
      bus_read_word(word_addr(REGION_IRQ, 0), rdata);
      if (rdata == 32'd5) break;
    end
    expect_value("irq", 32'd5, rdata);
    expect_value("irq_line", 32'd1, {31'd0, irq});
    bus_write_word(word_addr(REGION_IRQ, 0), 32'd1, 4'hf);
    bus_read_word(word_addr(REGION_IRQ, 0), rdata);
    expect_value("irq", 32'd4, rdata);
    expect_value("irq_line", 32'd1, {31'd0, irq});
    bus_write_word(word_addr(REGION_IRQ, 0), 32'd4, 4'hf);
    bus_read_word(word_addr(REGION_IRQ, 0), rdata);
    expect_value("irq", 32'd0, rdata);
    expect_value("irq_line", 32'd0, {31'd0, irq});
    ext_irq[1] = 1'b1;
    wait_cycles(4);
    ext_irq[1] = 1'b0;
    wait_cycles(2); // sync plus edge detect
    bus_read_word(word_addr(REGION_IRQ, 0), rdata);
    expect_value("irq", 32'd2, rdata);
    finish_test("irq");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped, no result after %0d cycles", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    bus_address    = '0;
    bus_read       = 1'b0;
    bus_write      = 1'b0;
    bus_writedata  = '0;
    bus_byteenable = '0;
    ext_irq        = '0;
    ps2_clk        = 1'b1; // PS/2 lines idle high
    ps2_data       = 1'b1;
    rng_state      = 32'd25880;
    check_count    = 0;
    error_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    cycle_count    = 0;
    wait_count     = 0;
    repeat (3) @(posedge clk);
    #2;
    reset_n = 1'b1;
    run_sram_random();
    run_unmapped();
    run_kb_frame();
    run_kb_resync();
    run_irq();
    wait (act_q.size() == 0);
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hw/soc_pkg.sv
hw/bus_fabric.sv
hw/main_sram.sv
hw/irq_ctrl.sv
hw/ps2_keyboard.sv
hw/periph_top.sv
tb/tb_top.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = \*\*\* TEST FAILED \*\*\*
PASS_MSG  = \*\*\* TEST PASSED \*\*\*

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
